// File: Makefile
TB = tb_simd_alu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f simd_alu.f --top-module simd_alu

sim:
	verilator --binary --timing --assert -j 0 -f simd_alu.f --top-module $(TB) -o sim_$(TB)
	./obj_dir/sim_$(TB) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: simd_alu.f
+incdir+.
simd_alu_pkg.sv
simd_alu_compare.sv
simd_alu_decode.sv
simd_alu_mul_unit.sv
simd_alu_execute.sv
simd_alu.sv
tb_simd_alu.sv

// File: simd_alu.sv
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_alu
  (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic [31:0]           control,
  input  simd_alu_pkg::word_t   src1,
  input  simd_alu_pkg::word_t   src2,
  input  simd_alu_pkg::word_t   src3,
  input  logic                  vcc_in,
  input  logic                  exec,
  output logic                  done,
  output simd_alu_pkg::word_t   vgpr_data,
  output logic                  vcc_out
  );

  logic                     issue_valid;
  simd_alu_pkg::alu_op_e    issue_op;
  simd_alu_pkg::cmp_cond_t  issue_cond;
  logic                     issue_signed;
  simd_alu_pkg::word_t      op_a;
  simd_alu_pkg::word_t      op_b;
  simd_alu_pkg::word_t      op_c;
  logic                     issue_vcc;
  logic                     mul_valid;
  simd_alu_pkg::alu_op_e    mul_op;
  simd_alu_pkg::word_t      mul_a;
  simd_alu_pkg::word_t      mul_b;
  logic                     mul_done;
  simd_alu_pkg::word_t      mul_result;

  simd_alu_decode u_decode
    (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .control      (control),
    .src1         (src1),
    .src2         (src2),
    .src3         (src3),
    .vcc_in       (vcc_in),
    .exec         (exec),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_cond   (issue_cond),
    .issue_signed (issue_signed),
    .op_a         (op_a),
    .op_b         (op_b),
    .op_c         (op_c),
    .issue_vcc    (issue_vcc),
    .mul_valid    (mul_valid),
    .mul_op       (mul_op),
    .mul_a        (mul_a),
    .mul_b        (mul_b)
    );

  simd_alu_mul_unit u_mul_unit
    (
    .clk        (clk),
    .rst        (rst),
    .mul_valid  (mul_valid),
    .mul_op     (mul_op),
    .mul_a      (mul_a),
    .mul_b      (mul_b),
    .mul_done   (mul_done),
    .mul_result (mul_result)
    );

  simd_alu_execute u_execute
    (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_cond   (issue_cond),
    .issue_signed (issue_signed),
    .op_a         (op_a),
    .op_b         (op_b),
    .op_c         (op_c),
    .issue_vcc    (issue_vcc),
    .mul_done     (mul_done),
    .mul_result   (mul_result),
    .done         (done),
    .vgpr_data    (vgpr_data),
    .vcc_out      (vcc_out)
    );

endmodule

// File: simd_alu_compare.sv
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_alu_compare
  (
  input  simd_alu_pkg::word_t       a,
  input  simd_alu_pkg::word_t       b,
  input  simd_alu_pkg::cmp_cond_t   cond,
  input  logic                      is_signed,
  output logic                      result
  );

  logic lt;
  logic eq;

  assign lt = is_signed ? ($signed(a) < $signed(b)) : (a < b);
  assign eq = (a == b);

  // Every condition comes from lt and eq
  always_comb
  begin
    case (cond)
      simd_alu_pkg::cmp_f:   result = 1'b0;
      simd_alu_pkg::cmp_lt:  result = lt;
      simd_alu_pkg::cmp_eq:  result = eq;
      simd_alu_pkg::cmp_le:  result = lt || eq;
      simd_alu_pkg::cmp_gt:  result = !(lt || eq);
      simd_alu_pkg::cmp_lg:  result = !eq;
      simd_alu_pkg::cmp_ge:  result = !lt;
      default:               result = 1'b1;   // TRU
    endcase
  end

endmodule

// File: simd_alu_decode.sv
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_alu_decode
  (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic [31:0]               control,
  input  simd_alu_pkg::word_t       src1,
  input  simd_alu_pkg::word_t       src2,
  input  simd_alu_pkg::word_t       src3,
  input  logic                      vcc_in,
  input  logic                      exec,
  output logic                      issue_valid,
  output simd_alu_pkg::alu_op_e     issue_op,
  output simd_alu_pkg::cmp_cond_t   issue_cond,
  output logic                      issue_signed,
  output simd_alu_pkg::word_t       op_a,
  output simd_alu_pkg::word_t       op_b,
  output simd_alu_pkg::word_t       op_c,
  output logic                      issue_vcc,
  output logic                      mul_valid,
  output simd_alu_pkg::alu_op_e     mul_op,
  output simd_alu_pkg::word_t       mul_a,
  output simd_alu_pkg::word_t       mul_b
  );

  logic [7:0]             fmt;
  logic [11:0]            opc;
  logic                   is_3a;
  logic                   cmp_i;      // Signed compare group
  logic                   cmp_u;
  logic                   dec_ok;
  simd_alu_pkg::alu_op_e  dec_op;
  logic                   dec_mul;
  logic                   use_sgn;
  logic                   use_mod;

  // Signed form takes abs then neg and unsigned form takes neg only
  function automatic simd_alu_pkg::word_t modify
    (
    input simd_alu_pkg::word_t x,
    input logic                abs_en,
    input logic                neg_en,
    input logic                sgn
    );
    simd_alu_pkg::word_t v;
    v = (sgn && abs_en && x[`ALU_WORD_W-1]) ? -x : x;
    modify = neg_en ? -v : v;
  endfunction

  assign fmt   = control[`ALU_FMT_HI:`ALU_FMT_LO];
  assign opc   = control[`ALU_OPC_HI:`ALU_OPC_LO];
  assign is_3a = (fmt == `ALU_FMT_VOP3A);
  assign cmp_i = (fmt == `ALU_FMT_VOPC || is_3a) &&
                 {opc[11:`ALU_CMP_COND_W], 3'b000} == `ALU_OPC_CMP_F_I32;
  assign cmp_u = (fmt == `ALU_FMT_VOPC || is_3a) &&
                 {opc[11:`ALU_CMP_COND_W], 3'b000} == `ALU_OPC_CMP_F_U32;

  always_comb
  begin
    dec_ok = 1'b1;
    dec_op = simd_alu_pkg::op_cmp;
    if (!(cmp_i || cmp_u))
    begin
      case ({fmt, opc})
        {`ALU_FMT_VOP1, `ALU_OPC_MOV_B32}:        dec_op = simd_alu_pkg::op_mov;
        {`ALU_FMT_VOP2, `ALU_OPC_ADD_I32}:        dec_op = simd_alu_pkg::op_add;
        {`ALU_FMT_VOP2, `ALU_OPC_SUB_I32}:        dec_op = simd_alu_pkg::op_sub;
        {`ALU_FMT_VOP2, `ALU_OPC_SUBREV_I32}:     dec_op = simd_alu_pkg::op_subrev;
        {`ALU_FMT_VOP2, `ALU_OPC_ADDC_U32}:       dec_op = simd_alu_pkg::op_addc;
        {`ALU_FMT_VOP2, `ALU_OPC_AND_B32},
        {`ALU_FMT_VOP3A, `ALU_OPC_AND_B32_3A}:    dec_op = simd_alu_pkg::op_and;
        {`ALU_FMT_VOP2, `ALU_OPC_OR_B32}:         dec_op = simd_alu_pkg::op_or;
        {`ALU_FMT_VOP2, `ALU_OPC_LSHLREV_B32}:    dec_op = simd_alu_pkg::op_lshl;
        {`ALU_FMT_VOP2, `ALU_OPC_LSHRREV_B32}:    dec_op = simd_alu_pkg::op_lshr;
        {`ALU_FMT_VOP2, `ALU_OPC_ASHRREV_I32}:    dec_op = simd_alu_pkg::op_ashr;
        {`ALU_FMT_VOP2, `ALU_OPC_MIN_U32},
        {`ALU_FMT_VOP3A, `ALU_OPC_MIN_U32_3A}:    dec_op = simd_alu_pkg::op_min_u;
        {`ALU_FMT_VOP2, `ALU_OPC_MAX_U32},
        {`ALU_FMT_VOP3A, `ALU_OPC_MAX_U32_3A}:    dec_op = simd_alu_pkg::op_max_u;
        {`ALU_FMT_VOP2, `ALU_OPC_MAX_I32}:        dec_op = simd_alu_pkg::op_max_i;
        {`ALU_FMT_VOP2, `ALU_OPC_CNDMASK_B32}:    dec_op = simd_alu_pkg::op_cndmask;
        {`ALU_FMT_VOP3A, `ALU_OPC_BFE_U32}:       dec_op = simd_alu_pkg::op_bfe_u;
        {`ALU_FMT_VOP3A, `ALU_OPC_BFI_B32}:       dec_op = simd_alu_pkg::op_bfi;
        {`ALU_FMT_VOP3A, `ALU_OPC_MUL_LO_U32}:    dec_op = simd_alu_pkg::op_mul_lo_u;
        {`ALU_FMT_VOP3A, `ALU_OPC_MUL_HI_U32}:    dec_op = simd_alu_pkg::op_mul_hi_u;
        {`ALU_FMT_VOP3A, `ALU_OPC_MUL_LO_I32}:    dec_op = simd_alu_pkg::op_mul_lo_i;
        {`ALU_FMT_VOP2, `ALU_OPC_MUL_I32_I24},
        {`ALU_FMT_VOP3A, `ALU_OPC_MUL_I32_I24_3A}: dec_op = simd_alu_pkg::op_mul_i24;
        default:                                  dec_ok = 1'b0;
      endcase
    end
  end

  assign dec_mul = dec_op inside {simd_alu_pkg::op_mul_lo_u, simd_alu_pkg::op_mul_hi_u,
                                  simd_alu_pkg::op_mul_lo_i, simd_alu_pkg::op_mul_i24};
  assign use_sgn = cmp_i ||
                   dec_op inside {simd_alu_pkg::op_add, simd_alu_pkg::op_sub,
                                  simd_alu_pkg::op_subrev, simd_alu_pkg::op_max_i,
                                  simd_alu_pkg::op_ashr, simd_alu_pkg::op_mul_lo_i,
                                  simd_alu_pkg::op_mul_i24};
  // Bitwise operations ignore the modifiers
  assign use_mod = is_3a && !(dec_op inside {simd_alu_pkg::op_and, simd_alu_pkg::op_bfi});

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      issue_valid <= 1'b0;
      mul_valid   <= 1'b0;
    end
    else
    begin
      issue_valid <= start && exec && dec_ok && !dec_mul;
      mul_valid   <= start && exec && dec_ok && dec_mul;
    end
  end

  always_ff @(posedge clk)
  begin
    issue_op     <= dec_op;
    issue_cond   <= simd_alu_pkg::cmp_cond_t'(opc[`ALU_CMP_COND_W-1:0]);
    issue_signed <= use_sgn;
    issue_vcc    <= vcc_in;
    op_a <= modify(src1, use_mod && control[`ALU_ABS1_POS],
                   use_mod && control[`ALU_NEG1_POS], use_sgn);
    op_b <= modify(src2, use_mod && control[`ALU_ABS2_POS],
                   use_mod && control[`ALU_NEG2_POS], use_sgn);
    op_c <= modify(src3, use_mod && control[`ALU_ABS3_POS],
                   use_mod && control[`ALU_NEG3_POS], use_sgn);
  end

  assign mul_op = issue_op;   // Multiply shares the issue registers
  assign mul_a  = op_a;
  assign mul_b  = op_b;

  assert property (@(posedge clk) disable iff (rst) start |-> !$isunknown({exec, control}))
    else $error("start arrived with an unknown control word or exec bit");

endmodule

// File: simd_alu_execute.sv
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_alu_execute
  (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      issue_valid,
  input  simd_alu_pkg::alu_op_e     issue_op,
  input  simd_alu_pkg::cmp_cond_t   issue_cond,
  input  logic                      issue_signed,
  input  simd_alu_pkg::word_t       op_a,
  input  simd_alu_pkg::word_t       op_b,
  input  simd_alu_pkg::word_t       op_c,
  input  logic                      issue_vcc,
  input  logic                      mul_done,
  input  simd_alu_pkg::word_t       mul_result,
  output logic                      done,
  output simd_alu_pkg::word_t       vgpr_data,
  output logic                      vcc_out
  );

  logic [`ALU_WORD_W:0]       a_x;
  logic [`ALU_WORD_W:0]       b_x;
  logic [`ALU_WORD_W:0]       cin;
  logic [`ALU_WORD_W:0]       wide;     // Top bit is carry or borrow
  logic [`ALU_SHAMT_W-1:0]    shamt;
  simd_alu_pkg::word_t        bfe_mask;
  simd_alu_pkg::word_t        alu_data;
  logic                       alu_vcc;
  logic                       cmp_result;

  simd_alu_compare u_compare
    (
    .a         (op_a),
    .b         (op_b),
    .cond      (issue_cond),
    .is_signed (issue_signed),
    .result    (cmp_result)
    );

  assign a_x      = {1'b0, op_a};
  assign b_x      = {1'b0, op_b};
  assign cin      = {{`ALU_WORD_W{1'b0}}, issue_vcc};
  assign shamt    = op_a[`ALU_SHAMT_W-1:0];   // Reversed shifts take the amount from src1
  assign bfe_mask = (simd_alu_pkg::word_t'(1) << op_c[`ALU_SHAMT_W-1:0]) -
                    simd_alu_pkg::word_t'(1);

  always_comb
  begin
    case (issue_op)
      simd_alu_pkg::op_sub:    wide = a_x - b_x;
      simd_alu_pkg::op_subrev: wide = b_x - a_x;
      simd_alu_pkg::op_addc:   wide = a_x + b_x + cin;
      default:                 wide = a_x + b_x;
    endcase
  end

  always_comb
  begin
    alu_vcc = issue_vcc;
    case (issue_op)
      simd_alu_pkg::op_add, simd_alu_pkg::op_sub,
      simd_alu_pkg::op_subrev, simd_alu_pkg::op_addc:
      begin
        alu_data = wide[`ALU_WORD_W-1:0];
        alu_vcc  = wide[`ALU_WORD_W];
      end
      simd_alu_pkg::op_and:     alu_data = op_a & op_b;
      simd_alu_pkg::op_or:      alu_data = op_a | op_b;
      simd_alu_pkg::op_lshl:    alu_data = op_b << shamt;
      simd_alu_pkg::op_lshr:    alu_data = op_b >> shamt;
      simd_alu_pkg::op_ashr:    alu_data = $signed(op_b) >>> shamt;
      simd_alu_pkg::op_min_u:   alu_data = (op_a <= op_b) ? op_a : op_b;
      simd_alu_pkg::op_max_u:   alu_data = (op_a >= op_b) ? op_a : op_b;
      simd_alu_pkg::op_max_i:   alu_data = ($signed(op_a) >= $signed(op_b)) ? op_a : op_b;
      simd_alu_pkg::op_cndmask: alu_data = issue_vcc ? op_b : op_a;
      simd_alu_pkg::op_cmp:
      begin
        alu_data = '0;
        alu_vcc  = cmp_result;
      end
      simd_alu_pkg::op_bfe_u:   alu_data = (op_a >> op_b[`ALU_SHAMT_W-1:0]) & bfe_mask;
      simd_alu_pkg::op_bfi:     alu_data = (op_a & op_b) | (~op_a & op_c);
      default:                  alu_data = op_a;   // Move
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      done      <= 1'b0;
      vgpr_data <= '0;
      vcc_out   <= 1'b0;
    end
    else
    begin
      done <= issue_valid || mul_done;
      if (mul_done)
        vgpr_data <= mul_result;    // Multiplies leave vcc as it was
      else if (issue_valid)
      begin
        vgpr_data <= alu_data;
        vcc_out   <= alu_vcc;
      end
    end
  end

  // A single-cycle op two cycles after a multiply would collide here
  assert property (@(posedge clk) disable iff (rst) !(issue_valid && mul_done))
    else $error("single-cycle result collides with multiply result");

endmodule

// File: simd_alu_macros.svh
`ifndef SIMD_ALU_MACROS_SVH
`define SIMD_ALU_MACROS_SVH

`define ALU_WORD_W      32
`define ALU_SHAMT_W     5       // Shift and bit-field amount
`define ALU_MUL_STAGES  3       // Multiply pipeline depth
`define ALU_CMP_COND_W  3

// Control word fields
`define ALU_FMT_HI      31
`define ALU_FMT_LO      24
`define ALU_OPC_HI      11
`define ALU_OPC_LO      0

`define ALU_ABS1_POS    21      // VOP3A only
`define ALU_ABS2_POS    22
`define ALU_ABS3_POS    23
`define ALU_NEG1_POS    18
`define ALU_NEG2_POS    19
`define ALU_NEG3_POS    20

// Encoding formats
`define ALU_FMT_VOP1    8'h01
`define ALU_FMT_VOP2    8'h02
`define ALU_FMT_VOPC    8'h04
`define ALU_FMT_VOP3A   8'h08

// VOP1 / VOP2 opcodes
`define ALU_OPC_CNDMASK_B32     12'h000
`define ALU_OPC_MOV_B32         12'h001
`define ALU_OPC_MUL_I32_I24     12'h009
`define ALU_OPC_MAX_I32         12'h012
`define ALU_OPC_MIN_U32         12'h013
`define ALU_OPC_MAX_U32         12'h014
`define ALU_OPC_LSHRREV_B32     12'h016
`define ALU_OPC_ASHRREV_I32     12'h018
`define ALU_OPC_LSHLREV_B32     12'h01A
`define ALU_OPC_AND_B32         12'h01B
`define ALU_OPC_OR_B32          12'h01C
`define ALU_OPC_ADD_I32         12'h025
`define ALU_OPC_SUB_I32         12'h026
`define ALU_OPC_SUBREV_I32      12'h027
`define ALU_OPC_ADDC_U32        12'h028

// Compare groups, condition in the low 3 bits
`define ALU_OPC_CMP_F_I32       12'h080
`define ALU_OPC_CMP_F_U32       12'h0C0

// VOP3A opcodes
`define ALU_OPC_MUL_I32_I24_3A  12'h109
`define ALU_OPC_MIN_U32_3A      12'h113
`define ALU_OPC_MAX_U32_3A      12'h114
`define ALU_OPC_AND_B32_3A      12'h11B
`define ALU_OPC_BFE_U32         12'h148
`define ALU_OPC_BFI_B32         12'h14A
`define ALU_OPC_MUL_LO_U32      12'h169
`define ALU_OPC_MUL_HI_U32      12'h16A
`define ALU_OPC_MUL_LO_I32      12'h16B

`endif

// File: simd_alu_mul_unit.sv
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_alu_mul_unit
  (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mul_valid,
  input  simd_alu_pkg::alu_op_e     mul_op,
  input  simd_alu_pkg::word_t       mul_a,
  input  simd_alu_pkg::word_t       mul_b,
  output logic                      mul_done,
  output simd_alu_pkg::word_t       mul_result
  );

  simd_alu_pkg::dword_t   ext_a;
  simd_alu_pkg::dword_t   ext_b;
  simd_alu_pkg::dword_t   s1_a;
  simd_alu_pkg::dword_t   s1_b;
  simd_alu_pkg::alu_op_e  s1_op;
  logic                   s1_valid;
  simd_alu_pkg::dword_t   s2_prod;
  simd_alu_pkg::alu_op_e  s2_op;
  logic                   s2_valid;

  // Extension to 64 bits makes the low product correct for signed operands
  always_comb
  begin
    case (mul_op)
      simd_alu_pkg::op_mul_i24:
      begin
        ext_a = {{40{mul_a[23]}}, mul_a[23:0]};
        ext_b = {{40{mul_b[23]}}, mul_b[23:0]};
      end
      simd_alu_pkg::op_mul_lo_i:
      begin
        ext_a = {{`ALU_WORD_W{mul_a[`ALU_WORD_W-1]}}, mul_a};
        ext_b = {{`ALU_WORD_W{mul_b[`ALU_WORD_W-1]}}, mul_b};
      end
      default:
      begin
        ext_a = {{`ALU_WORD_W{1'b0}}, mul_a};
        ext_b = {{`ALU_WORD_W{1'b0}}, mul_b};
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end
    else
    begin
      s1_valid <= mul_valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    s1_a    <= ext_a;     // Stage 1 operands
    s1_b    <= ext_b;
    s1_op   <= mul_op;
    s2_prod <= s1_a * s1_b;   // Stage 2 product
    s2_op   <= s1_op;
  end

  // Stage 3 half select feeds the execute output register
  assign mul_done   = s2_valid;
  assign mul_result = (s2_op == simd_alu_pkg::op_mul_hi_u) ?
                      s2_prod[2*`ALU_WORD_W-1:`ALU_WORD_W] : s2_prod[`ALU_WORD_W-1:0];

  assert property (@(posedge clk) disable iff (rst)
                   mul_valid |-> mul_op inside {simd_alu_pkg::op_mul_lo_u,
                                                simd_alu_pkg::op_mul_hi_u,
                                                simd_alu_pkg::op_mul_lo_i,
                                                simd_alu_pkg::op_mul_i24})
    else $error("multiply unit received a non-multiply operation");

endmodule

// File: simd_alu_pkg.sv
`include "simd_alu_macros.svh"

package simd_alu_pkg;

  typedef logic [`ALU_WORD_W-1:0]   word_t;
  typedef logic [2*`ALU_WORD_W-1:0] dword_t;    // Full product

  typedef enum logic [4:0] {
    op_mov,
    op_add,
    op_sub,
    op_subrev,
    op_addc,
    op_and,
    op_or,
    op_lshl,
    op_lshr,
    op_ashr,
    op_min_u,
    op_max_u,
    op_max_i,
    op_cndmask,
    op_cmp,
    op_bfe_u,
    op_bfi,
    op_mul_lo_u,
    op_mul_hi_u,
    op_mul_lo_i,
    op_mul_i24
  } alu_op_e;

  // Order follows the low opcode bits of the compare groups
  typedef enum logic [`ALU_CMP_COND_W-1:0] {
    cmp_f,
    cmp_lt,
    cmp_eq,
    cmp_le,
    cmp_gt,
    cmp_lg,
    cmp_ge,
    cmp_tru
  } cmp_cond_t;

endpackage

// File: tb_simd_alu_ref.svh
`ifndef TB_SIMD_ALU_REF_SVH
`define TB_SIMD_ALU_REF_SVH

// Fibonacci step with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] apply_mods(input logic [31:0] x, input logic abs_en,
                                           input logic neg_en, input logic sgn);
  logic [31:0] v;
  v = x;
  if (sgn && abs_en && x[31])
    v = 32'h0 - x;        // Abs only on the signed path
  if (neg_en)
    v = 32'h0 - v;
  apply_mods = v;
endfunction

function automatic logic compare_ref(input logic [31:0] a, input logic [31:0] b,
                                     input logic [2:0] cond, input logic sgn);
  logic lt;
  logic gt;
  lt = sgn ? ($signed(a) < $signed(b)) : (a < b);
  gt = sgn ? ($signed(a) > $signed(b)) : (a > b);
  case (cond)
    3'd0:    compare_ref = 1'b0;
    3'd1:    compare_ref = lt;
    3'd2:    compare_ref = (a == b);
    3'd3:    compare_ref = !gt;
    3'd4:    compare_ref = gt;
    3'd5:    compare_ref = (a != b);
    3'd6:    compare_ref = !lt;
    default: compare_ref = 1'b1;
  endcase
endfunction

// Latency 0 means the instruction must not produce done
function automatic void ref_model(input logic [31:0] ctrl, input logic [31:0] s1,
                                  input logic [31:0] s2, input logic [31:0] s3,
                                  input logic vin, input logic ex, output int lat,
                                  output logic [31:0] data, output logic upd_vcc,
                                  output logic vcc);
  logic [7:0]  fmt;
  logic [11:0] opc;
  logic        v3a;
  logic        cmp_s;
  logic        cmp_u;
  logic        sgn;
  logic        mod_en;
  logic        is_mul;
  logic        is_carry;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [32:0] w;
  logic [63:0] p;
  fmt    = ctrl[31:24];
  opc    = ctrl[11:0];
  v3a    = (fmt == `ALU_FMT_VOP3A);
  cmp_s  = (fmt == `ALU_FMT_VOPC || v3a) && ((opc & 12'hFF8) == `ALU_OPC_CMP_F_I32);
  cmp_u  = (fmt == `ALU_FMT_VOPC || v3a) && ((opc & 12'hFF8) == `ALU_OPC_CMP_F_U32);
  sgn    = cmp_s || (v3a && (opc == `ALU_OPC_MUL_LO_I32 || opc == `ALU_OPC_MUL_I32_I24_3A));
  mod_en = v3a && opc != `ALU_OPC_AND_B32_3A && opc != `ALU_OPC_BFI_B32;
  is_mul = (v3a && opc inside {`ALU_OPC_MUL_LO_U32, `ALU_OPC_MUL_HI_U32,
                               `ALU_OPC_MUL_LO_I32, `ALU_OPC_MUL_I32_I24_3A}) ||
           (fmt == `ALU_FMT_VOP2 && opc == `ALU_OPC_MUL_I32_I24);
  is_carry = (fmt == `ALU_FMT_VOP2) && opc inside {`ALU_OPC_ADD_I32, `ALU_OPC_SUB_I32,
                                                   `ALU_OPC_SUBREV_I32, `ALU_OPC_ADDC_U32};
  a = apply_mods(s1, mod_en && ctrl[`ALU_ABS1_POS], mod_en && ctrl[`ALU_NEG1_POS], sgn);
  b = apply_mods(s2, mod_en && ctrl[`ALU_ABS2_POS], mod_en && ctrl[`ALU_NEG2_POS], sgn);
  c = apply_mods(s3, mod_en && ctrl[`ALU_ABS3_POS], mod_en && ctrl[`ALU_NEG3_POS], sgn);
  lat     = 2;
  data    = 32'h0;
  upd_vcc = 1'b1;
  vcc     = vin;              // Passes through unless the op defines it
  w       = 33'h0;
  if (cmp_s || cmp_u)
    vcc = compare_ref(a, b, opc[2:0], cmp_s);
  else
  begin
    case ({fmt, opc})
      {`ALU_FMT_VOP1, `ALU_OPC_MOV_B32}:       data = a;
      {`ALU_FMT_VOP2, `ALU_OPC_ADD_I32}:       w = {1'b0, a} + {1'b0, b};
      {`ALU_FMT_VOP2, `ALU_OPC_SUB_I32}:       w = {1'b0, a} - {1'b0, b};
      {`ALU_FMT_VOP2, `ALU_OPC_SUBREV_I32}:    w = {1'b0, b} - {1'b0, a};
      {`ALU_FMT_VOP2, `ALU_OPC_ADDC_U32}:      w = {1'b0, a} + {1'b0, b} + {32'h0, vin};
      {`ALU_FMT_VOP2, `ALU_OPC_AND_B32},
      {`ALU_FMT_VOP3A, `ALU_OPC_AND_B32_3A}:   data = a & b;
      {`ALU_FMT_VOP2, `ALU_OPC_OR_B32}:        data = a | b;
      {`ALU_FMT_VOP2, `ALU_OPC_LSHLREV_B32}:   data = b << a[4:0];
      {`ALU_FMT_VOP2, `ALU_OPC_LSHRREV_B32}:   data = b >> a[4:0];
      {`ALU_FMT_VOP2, `ALU_OPC_ASHRREV_I32}:
        data = (b >> a[4:0]) | (b[31] ? ~(32'hFFFF_FFFF >> a[4:0]) : 32'h0);
      {`ALU_FMT_VOP2, `ALU_OPC_MIN_U32},
      {`ALU_FMT_VOP3A, `ALU_OPC_MIN_U32_3A}:   data = (a < b) ? a : b;
      {`ALU_FMT_VOP2, `ALU_OPC_MAX_U32},
      {`ALU_FMT_VOP3A, `ALU_OPC_MAX_U32_3A}:   data = (a > b) ? a : b;
      {`ALU_FMT_VOP2, `ALU_OPC_MAX_I32}:       data = ($signed(a) > $signed(b)) ? a : b;
      {`ALU_FMT_VOP2, `ALU_OPC_CNDMASK_B32}:   data = vin ? b : a;
      {`ALU_FMT_VOP3A, `ALU_OPC_BFE_U32}:
        for (int i = 0; i < 32; i++)           // Field of c[4:0] bits from offset b[4:0]
          if (i < c[4:0] && i + b[4:0] < 32)
            data[i] = a[i + b[4:0]];
      {`ALU_FMT_VOP3A, `ALU_OPC_BFI_B32}:      data = c ^ ((b ^ c) & a);   // a picks b over c
      {`ALU_FMT_VOP3A, `ALU_OPC_MUL_LO_U32},
      {`ALU_FMT_VOP3A, `ALU_OPC_MUL_LO_I32}:   data = a * b;   // Low half is sign independent
      {`ALU_FMT_VOP3A, `ALU_OPC_MUL_HI_U32}:
      begin
        p    = {32'h0, a} * {32'h0, b};
        data = p[63:32];
      end
      {`ALU_FMT_VOP2, `ALU_OPC_MUL_I32_I24},
      {`ALU_FMT_VOP3A, `ALU_OPC_MUL_I32_I24_3A}:
        data = {{8{a[23]}}, a[23:0]} * {{8{b[23]}}, b[23:0]};
      default:                                 lat = 0;
    endcase
  end
  if (is_carry)
  begin
    data = w[31:0];
    vcc  = w[32];
  end
  if (is_mul)
  begin
    lat     = 4;
    upd_vcc = 1'b0;           // Multiplies keep the previous vcc
  end
  if (!ex)
    lat = 0;
endfunction

`endif

// File: tb_simd_alu.sv
`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module tb_simd_alu;

  typedef struct packed {
    int          due;
    logic [31:0] data;
    logic        upd_vcc;
    logic        vcc;
  } exp_t;

  logic                 clk;
  logic                 rst;
  logic                 start;
  logic [31:0]          control;
  simd_alu_pkg::word_t  src1;
  simd_alu_pkg::word_t  src2;
  simd_alu_pkg::word_t  src3;
  logic                 vcc_in;
  logic                 exec;
  logic                 done;
  simd_alu_pkg::word_t  vgpr_data;
  logic                 vcc_out;

  exp_t         pending[$];       // Expected results, each with its due cycle
  int           cycle;
  int           errors;
  int           checks;
  logic [31:0]  lfsr_state;
  logic [31:0]  exp_data;
  logic         exp_vcc;

  // Format and opcode of the single-cycle ops, run back to back
  logic [19:0]  single_ops [15] = '{
    {`ALU_FMT_VOP1, `ALU_OPC_MOV_B32},      {`ALU_FMT_VOP2, `ALU_OPC_AND_B32},
    {`ALU_FMT_VOP2, `ALU_OPC_OR_B32},       {`ALU_FMT_VOP2, `ALU_OPC_LSHLREV_B32},
    {`ALU_FMT_VOP2, `ALU_OPC_LSHRREV_B32},  {`ALU_FMT_VOP2, `ALU_OPC_ASHRREV_I32},
    {`ALU_FMT_VOP2, `ALU_OPC_MIN_U32},      {`ALU_FMT_VOP2, `ALU_OPC_MAX_U32},
    {`ALU_FMT_VOP2, `ALU_OPC_MAX_I32},      {`ALU_FMT_VOP2, `ALU_OPC_CNDMASK_B32},
    {`ALU_FMT_VOP3A, `ALU_OPC_AND_B32_3A},  {`ALU_FMT_VOP3A, `ALU_OPC_MIN_U32_3A},
    {`ALU_FMT_VOP3A, `ALU_OPC_MAX_U32_3A},  {`ALU_FMT_VOP3A, `ALU_OPC_BFE_U32},
    {`ALU_FMT_VOP3A, `ALU_OPC_BFI_B32}
  };

  `include "tb_simd_alu_ref.svh"

  simd_alu UUT
    (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .control   (control),
    .src1      (src1),
    .src2      (src2),
    .src3      (src3),
    .vcc_in    (vcc_in),
    .exec      (exec),
    .done      (done),
    .vgpr_data (vgpr_data),
    .vcc_out   (vcc_out)
    );

  always #20 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = 32'h0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    take_bits = r;
  endfunction

  // Edge values near 0 and all ones, or a random word
  function automatic logic [31:0] pick_operand();
    logic [31:0] t;
    t = take_bits(3);
    case (t[2:0])
      3'd0:    pick_operand = 32'h0000_0000;
      3'd1:    pick_operand = 32'h0000_0001;
      3'd2:    pick_operand = 32'hFFFF_FFFF;
      3'd3:    pick_operand = 32'hFFFF_FFFE;
      3'd4:    pick_operand = 32'h8000_0000;
      3'd5:    pick_operand = 32'h7FFF_FFFF;
      default: pick_operand = take_bits(32);
    endcase
  endfunction

  function automatic logic [31:0] make_control(input logic [7:0] fmt, input logic [11:0] opc,
                                               input logic [5:0] mods);
    make_control = {fmt, mods, 6'h00, opc};   // mods are abs3..abs1, neg3..neg1
  endfunction

  task automatic issue(input logic [31:0] ctrl, input logic [31:0] a, input logic [31:0] b,
                       input logic [31:0] c, input logic vin, input logic ex);
    exp_t        e;
    int          lat;
    logic [31:0] d;
    logic        upd;
    logic        v;
    @(posedge clk);
    #2;
    start   = 1'b1;
    control = ctrl;
    src1    = a;
    src2    = b;
    src3    = c;
    vcc_in  = vin;
    exec    = ex;
    ref_model(ctrl, a, b, c, vin, ex, lat, d, upd, v);
    if (lat > 0)
    begin
      e.due     = cycle + lat;
      e.data    = d;
      e.upd_vcc = upd;
      e.vcc     = v;
      pending.push_back(e);
    end
  endtask

  task automatic random_issue(input logic [31:0] ctrl, input logic ex);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] v;
    a = pick_operand();
    b = pick_operand();
    c = pick_operand();
    v = take_bits(1);
    issue(ctrl, a, b, c, v[0], ex);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
      start = 1'b0;
    end
  endtask

  task automatic run_arith(input int n);
    logic [31:0] t;
    logic [11:0] opc;
    for (int i = 0; i < n; i++)
    begin
      t = take_bits(2);
      case (t[1:0])
        2'd0:    opc = `ALU_OPC_ADD_I32;
        2'd1:    opc = `ALU_OPC_SUB_I32;
        2'd2:    opc = `ALU_OPC_SUBREV_I32;
        default: opc = `ALU_OPC_ADDC_U32;
      endcase
      random_issue(make_control(`ALU_FMT_VOP2, opc, 6'h00), 1'b1);
    end
    idle(6);
  endtask

  task automatic run_single(input int rounds);
    for (int r = 0; r < rounds; r++)
      for (int i = 0; i < 15; i++)
        random_issue(make_control(single_ops[i][19:12], single_ops[i][11:0], 6'h00), 1'b1);
    idle(6);
  endtask

  task automatic run_compares(input int rounds);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] t;
    logic [11:0] opc;
    for (int r = 0; r < rounds; r++)
      for (int k = 0; k < 32; k++)
      begin
        opc = (k[3] ? `ALU_OPC_CMP_F_U32 : `ALU_OPC_CMP_F_I32) | {9'h000, k[2:0]};
        a   = pick_operand();
        t   = take_bits(7);
        b   = t[6] ? a : pick_operand();   // Equal operands now and then
        if (k[4])
          issue(make_control(`ALU_FMT_VOP3A, opc, t[5:0]), a, b, 32'h0, t[0], 1'b1);
        else
          issue(make_control(`ALU_FMT_VOPC, opc, 6'h00), a, b, 32'h0, t[1], 1'b1);
      end
    idle(6);
  endtask

  task automatic run_multiplies(input int rounds);
    logic [31:0] t;
    for (int r = 0; r < rounds; r++)
    begin
      t = take_bits(6);
      random_issue(make_control(`ALU_FMT_VOP3A, `ALU_OPC_MUL_LO_U32, t[5:0]), 1'b1);
      random_issue(make_control(`ALU_FMT_VOP3A, `ALU_OPC_MUL_HI_U32, t[5:0]), 1'b1);
      random_issue(make_control(`ALU_FMT_VOP3A, `ALU_OPC_MUL_LO_I32, t[5:0]), 1'b1);
      random_issue(make_control(`ALU_FMT_VOP2, `ALU_OPC_MUL_I32_I24, 6'h00), 1'b1);
      random_issue(make_control(`ALU_FMT_VOP3A, `ALU_OPC_MUL_I32_I24_3A, t[5:0]), 1'b1);
      idle(6);
    end
    // Add after a multiply finishes first, the cycle m+2 slot stays empty
    random_issue(make_control(`ALU_FMT_VOP3A, `ALU_OPC_MUL_HI_U32, 6'h00), 1'b1);
    random_issue(make_control(`ALU_FMT_VOP2, `ALU_OPC_ADD_I32, 6'h00), 1'b1);
    idle(1);
    random_issue(make_control(`ALU_FMT_VOP2, `ALU_OPC_SUB_I32, 6'h00), 1'b1);
    idle(6);
  endtask

  task automatic run_no_done();
    random_issue(make_control(`ALU_FMT_VOP2, `ALU_OPC_ADD_I32, 6'h00), 1'b1);
    random_issue(make_control(`ALU_FMT_VOP2, `ALU_OPC_ADD_I32, 6'h00), 1'b0);
    random_issue(make_control(`ALU_FMT_VOP2, 12'h0FF, 6'h00), 1'b1);
    random_issue(make_control(8'h10, `ALU_OPC_ADD_I32, 6'h00), 1'b1);
    random_issue(make_control(`ALU_FMT_VOP3A, `ALU_OPC_MUL_LO_U32, 6'h00), 1'b0);
    random_issue(make_control(`ALU_FMT_VOP2, `ALU_OPC_OR_B32, 6'h00), 1'b1);
    idle(6);
  endtask

  task automatic check_cycle();
    int   idx;
    logic exp_done;
    idx = -1;
    for (int i = 0; i < pending.size(); i++)
      if (pending[i].due == cycle)
        idx = i;
    exp_done = (idx >= 0);
    if (exp_done)
    begin
      exp_data = pending[idx].data;
      if (pending[idx].upd_vcc)
        exp_vcc = pending[idx].vcc;
      pending.delete(idx);
    end
    checks++;
    if (done !== exp_done)
    begin
      $display("ERR %0t done expected %b got %b", $time, exp_done, done);
      errors++;
    end
    if (vgpr_data !== exp_data)
    begin
      $display("ERR %0t vgpr_data expected %h got %h", $time, exp_data, vgpr_data);
      errors++;
    end
    if (vcc_out !== exp_vcc)
    begin
      $display("ERR %0t vcc_out expected %b got %b", $time, exp_vcc, vcc_out);
      errors++;
    end
  endtask

  // Outputs settle after the rising edge, sample mid cycle
  always @(negedge clk)
    if (!rst)
      check_cycle();

  initial
  begin
    int wait_cycles;
    clk        = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    control    = 32'h0;
    src1       = 32'h0;
    src2       = 32'h0;
    src3       = 32'h0;
    vcc_in     = 1'b0;
    exec       = 1'b0;
    cycle      = 0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'hd1df2e1a;
    exp_data   = 32'h0;
    exp_vcc    = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    idle(4);                    // Quiet outputs after reset
    run_arith(48);
    run_single(3);
    run_compares(2);
    run_multiplies(4);
    run_no_done();
    wait_cycles = 0;
    while (pending.size() > 0 && wait_cycles < 50)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (pending.size() > 0)
    begin
      $display("Timed out with %0d results never checked", pending.size());
      errors++;
    end
    @(posedge clk);
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule
